//--- transpose_cfg_pkg.sv
package transpose_cfg_pkg;

	// element and beat sizing
	localparam int unsigned DAT_DW = 8;
	localparam int unsigned TOUT = 4;
	localparam int unsigned TIN = 16;

	// channel groups per buffer row, also the max group count
	localparam int unsigned LANE_RATIO = TIN / TOUT;

	localparam int unsigned BURST_LEN = 8;
	localparam int unsigned W_MAX = 32;

	localparam int unsigned BEAT_W = DAT_DW * TOUT;

	// one slice per pixel and group
	localparam int unsigned BUF_DEPTH = W_MAX * LANE_RATIO;
	localparam int unsigned BUF_AW = $clog2(BUF_DEPTH);

	// csr field widths
	localparam int unsigned W_BITS = $clog2(W_MAX) + 1;
	localparam int unsigned GRP_BITS = $clog2(LANE_RATIO) + 1;

	// counter widths
	localparam int unsigned PIX_BITS = $clog2(BURST_LEN);
	localparam int unsigned GIDX_BITS = $clog2(LANE_RATIO);
	localparam int unsigned BURST_BITS = $clog2(W_MAX / BURST_LEN);

	// one spare bit so an out-of-range address stays visible
	localparam int unsigned XADDR_W = BUF_AW + 1;

endpackage

//--- transpose_types_pkg.sv
package transpose_types_pkg;

	import transpose_cfg_pkg::*;

	typedef enum logic {
		IDLE = 1'b0,
		BUSY = 1'b1
	} xpose_state_e;

	// tile shape from the csr side
	typedef struct packed {
		logic [W_BITS-1:0]   w_in;
		logic [GRP_BITS-1:0] ch_groups;
	} tile_cfg_t;

	// position of the beat currently offered
	typedef struct packed {
		logic [PIX_BITS-1:0]   pix;
		logic [GIDX_BITS-1:0]  grp;
		logic [BURST_BITS-1:0] burst;
		logic                  tile_last;
	} cnt_status_t;

	// one slice write into the transpose buffer
	typedef struct packed {
		logic              en;
		logic [BUF_AW-1:0] addr;
		logic [BEAT_W-1:0] data;
	} buf_wr_t;

endpackage

//--- transpose_ctrl.sv
module transpose_ctrl
	import transpose_types_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic rd_resp_vld,
	input  logic buf_grant,
	input  logic tile_last,
	output logic rd_resp_rdy,
	output logic rd_fifo_pop,
	output logic beat_acc,
	output logic busy,
	output logic done
);

	xpose_state_e state;
	xpose_state_e state_nxt;
	logic         tile_end;

	assign busy = (state == BUSY);

	// only accept while busy and the buffer side can take it
	assign rd_resp_rdy = busy & buf_grant;
	assign beat_acc = rd_resp_vld & rd_resp_rdy;
	assign rd_fifo_pop = beat_acc;

	assign tile_end = beat_acc & tile_last;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = BUSY;
				end
			end
			BUSY: begin
				// stay busy until the final beat, start is ignored here
				if (tile_end) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			done <= 1'b0;
		end else begin
			state <= state_nxt;
			done <= tile_end;
		end
	end

	// done follows a busy cycle and lands in idle
	a_done_from_busy: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(state == BUSY) && (state == IDLE));

	// ready only inside a tile that a start opened
	a_rdy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		rd_resp_rdy |-> $past(state == BUSY) || $past(start));

endmodule

//--- transpose_counters.sv
module transpose_counters
	import transpose_cfg_pkg::*, transpose_types_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  tile_cfg_t   cfg,
	input  logic        beat_acc,
	output cnt_status_t status
);

	tile_cfg_t             cfg_q;
	logic [PIX_BITS-1:0]   pix_cnt;
	logic [GIDX_BITS-1:0]  grp_cnt;
	logic [BURST_BITS-1:0] burst_cnt;
	logic [W_BITS-1:0]     w_m1;
	logic [BURST_BITS-1:0] burst_max;
	logic [PIX_BITS-1:0]   pix_max;
	logic [GIDX_BITS-1:0]  grp_max;
	logic                  pix_wrap;
	logic                  grp_wrap;
	logic                  burst_wrap;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q <= '0;
		end else if (start) begin
			cfg_q <= cfg;
		end
	end

	// index of the final burst
	assign w_m1 = cfg_q.w_in - W_BITS'(1);
	assign burst_max = BURST_BITS'(w_m1 >> PIX_BITS);

	// last burst is partial, ((w_in-1) mod BURST_LEN)+1 beats
	assign pix_max = (burst_cnt == burst_max) ? w_m1[PIX_BITS-1:0]
		: PIX_BITS'(BURST_LEN - 1);
	assign grp_max = GIDX_BITS'(cfg_q.ch_groups - GRP_BITS'(1));

	assign pix_wrap = (pix_cnt == pix_max);
	assign grp_wrap = (grp_cnt == grp_max);
	assign burst_wrap = (burst_cnt == burst_max);

	// pixel in burst, innermost
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_cnt <= '0;
		end else if (start) begin
			pix_cnt <= '0;
		end else if (beat_acc) begin
			if (pix_wrap) begin
				pix_cnt <= '0;
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grp_cnt <= '0;
		end else if (start) begin
			grp_cnt <= '0;
		end else if (beat_acc && pix_wrap) begin
			if (grp_wrap) begin
				grp_cnt <= '0;
			end else begin
				grp_cnt <= grp_cnt + 1'b1;
			end
		end
	end

	// burst, outermost
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			burst_cnt <= '0;
		end else if (start) begin
			burst_cnt <= '0;
		end else if (beat_acc && pix_wrap && grp_wrap) begin
			if (burst_wrap) begin
				burst_cnt <= '0;
			end else begin
				burst_cnt <= burst_cnt + 1'b1;
			end
		end
	end

	assign status.pix = pix_cnt;
	assign status.grp = grp_cnt;
	assign status.burst = burst_cnt;
	assign status.tile_last = pix_wrap & grp_wrap & burst_wrap;

	// group must stay inside the configured channel groups
	a_grp_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		beat_acc |-> (GRP_BITS'(grp_cnt) < cfg_q.ch_groups));

endmodule

//--- transpose_addr_gen.sv
module transpose_addr_gen
	import transpose_cfg_pkg::*, transpose_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              beat_acc,
	input  cnt_status_t       status,
	input  logic [BEAT_W-1:0] rd_dat,
	output buf_wr_t           wr
);

	logic [XADDR_W-1:0] abs_pix;
	logic [XADDR_W-1:0] abs_addr;
	logic               wr_en;
	logic [BUF_AW-1:0]  wr_addr;
	logic [BEAT_W-1:0]  wr_data;

	// pixel across bursts
	assign abs_pix = XADDR_W'(status.burst) * XADDR_W'(BURST_LEN) + XADDR_W'(status.pix);

	// pixel-major, channel group as the minor index
	assign abs_addr = abs_pix * XADDR_W'(LANE_RATIO) + XADDR_W'(status.grp);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= beat_acc;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_acc) begin
			wr_addr <= abs_addr[BUF_AW-1:0];
			wr_data <= rd_dat;
		end
	end

	assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

	// back-to-back writes of one tile never reuse a slice
	a_addr_advances: assert property (@(posedge clk) disable iff (!rst_n)
		wr.en && $past(wr.en) |-> (wr.addr != $past(wr.addr)));

endmodule

//--- transpose_buffer.sv
module transpose_buffer
	import transpose_cfg_pkg::*, transpose_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  buf_wr_t           wr,
	input  logic              rd_en,
	input  logic [BUF_AW-1:0] rd_addr,
	output logic [BEAT_W-1:0] rd_q
);

	logic [BEAT_W-1:0] mem [BUF_DEPTH];

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// registered read, a same-address write in this cycle is not seen yet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_q <= '0;
		end else if (rd_en) begin
			rd_q <= mem[rd_addr];
		end
	end

endmodule

//--- transpose_unit.sv
module transpose_unit
	import transpose_cfg_pkg::*, transpose_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	input  logic              start,
	input  tile_cfg_t         cfg,

	// read response
	input  logic              rd_resp_vld,
	input  logic [BEAT_W-1:0] rd_dat,
	output logic              rd_resp_rdy,
	output logic              rd_fifo_pop,

	input  logic              buf_grant,

	output logic              busy,
	output logic              done,

	// readout for the next stage
	input  logic              rd_en,
	input  logic [BUF_AW-1:0] rd_addr,
	output logic [BEAT_W-1:0] rd_q
);

	logic        beat_acc;
	logic        tile_start;
	cnt_status_t status;
	buf_wr_t     wr;

	// a start during a tile must not disturb the counters
	assign tile_start = start & ~busy;

	transpose_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.rd_resp_vld (rd_resp_vld),
		.buf_grant   (buf_grant),
		.tile_last   (status.tile_last),
		.rd_resp_rdy (rd_resp_rdy),
		.rd_fifo_pop (rd_fifo_pop),
		.beat_acc    (beat_acc),
		.busy        (busy),
		.done        (done)
	);

	transpose_counters u_counters (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (tile_start),
		.cfg      (cfg),
		.beat_acc (beat_acc),
		.status   (status)
	);

	transpose_addr_gen u_addr_gen (
		.clk      (clk),
		.rst_n    (rst_n),
		.beat_acc (beat_acc),
		.status   (status),
		.rd_dat   (rd_dat),
		.wr       (wr)
	);

	transpose_buffer u_buffer (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (wr),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_q    (rd_q)
	);

endmodule

//--- tb_transpose_unit.sv
module tb_transpose_unit
	import transpose_cfg_pkg::*, transpose_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [W_BITS-1:0]   w_in;
		logic [GRP_BITS-1:0] ch_groups;
		logic [15:0]         vld_mask;
		logic [15:0]         grant_mask;
		logic                restart;
	} test_row_t;

	logic              clk;
	logic              rst_n;
	logic              start;
	tile_cfg_t         cfg;
	logic              rd_resp_vld;
	logic [BEAT_W-1:0] rd_dat;
	logic              rd_resp_rdy;
	logic              rd_fifo_pop;
	logic              buf_grant;
	logic              busy;
	logic              done;
	logic              rd_en;
	logic [BUF_AW-1:0] rd_addr;
	logic [BEAT_W-1:0] rd_q;

	test_row_t         tests [$];
	int unsigned       exp_addr [$];
	logic [BEAT_W-1:0] model [BUF_DEPTH];
	int unsigned       lcg_state = 48;
	int unsigned       errors = 0;
	int unsigned       checks = 0;
	int unsigned       done_seen = 0;

	transpose_unit dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.cfg         (cfg),
		.rd_resp_vld (rd_resp_vld),
		.rd_dat      (rd_dat),
		.rd_resp_rdy (rd_resp_rdy),
		.rd_fifo_pop (rd_fifo_pop),
		.buf_grant   (buf_grant),
		.busy        (busy),
		.done        (done),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_q        (rd_q)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(negedge clk) begin
		if (done) begin
			done_seen++;
		end
	end

	function automatic logic [BEAT_W-1:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return BEAT_W'(lcg_state);
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_beat(input string name, input logic [BEAT_W-1:0] exp,
		input logic [BEAT_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected 0x%08h, got 0x%08h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_count(input string name, input int unsigned exp,
		input int unsigned act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
		end
	endtask

	task automatic add_row(input int unsigned w, input int unsigned g,
		input logic [15:0] vm, input logic [15:0] gm, input logic rs);
		test_row_t r;
		r.w_in = W_BITS'(w);
		r.ch_groups = GRP_BITS'(g);
		r.vld_mask = vm;
		r.grant_mask = gm;
		r.restart = rs;
		tests.push_back(r);
	endtask

	task automatic report_test(input string what, input int unsigned err0);
		if (errors == err0) begin
			$display("%s: ok", what);
		end else begin
			$display("%s: %0d errors", what, errors - err0);
		end
	endtask

	// expected arrival order: burst, then group, then pixel
	task automatic build_order(input int unsigned w, input int unsigned g);
		int unsigned nbursts;
		int unsigned blen;
		exp_addr.delete();
		nbursts = (w - 1) / BURST_LEN + 1;
		for (int unsigned b = 0; b < nbursts; b++) begin
			blen = (b == nbursts - 1) ? ((w - 1) % BURST_LEN) + 1 : BURST_LEN;
			for (int unsigned grp = 0; grp < g; grp++) begin
				for (int unsigned p = 0; p < blen; p++) begin
					exp_addr.push_back((b * BURST_LEN + p) * LANE_RATIO + grp);
				end
			end
		end
	endtask

	task automatic check_idle();
		int unsigned err0;
		err0 = errors;
		@(negedge clk);
		check_bit("busy", 1'b0, busy);
		check_bit("done", 1'b0, done);
		check_bit("rd_resp_rdy", 1'b0, rd_resp_rdy);
		check_bit("rd_fifo_pop", 1'b0, rd_fifo_pop);
		// offered beats must be refused while idle
		repeat (3) begin
			@(posedge clk);
			#2;
			rd_resp_vld = 1'b1;
			buf_grant = 1'b1;
			rd_dat = next_rand();
			@(negedge clk);
			check_bit("rd_resp_rdy", 1'b0, rd_resp_rdy);
			check_bit("rd_fifo_pop", 1'b0, rd_fifo_pop);
			check_bit("busy", 1'b0, busy);
		end
		@(posedge clk);
		#2;
		rd_resp_vld = 1'b0;
		check_count("done pulses", 0, done_seen);
		report_test("test 0 idle after reset", err0);
	endtask

	task automatic run_tile(input int idx, input test_row_t row);
		int unsigned err0;
		int unsigned total;
		int unsigned beat;
		int unsigned k;
		int unsigned pops;
		logic vld;
		logic grant;
		logic [BEAT_W-1:0] cur;
		err0 = errors;
		build_order(row.w_in, row.ch_groups);
		total = exp_addr.size();
		@(posedge clk);
		#2;
		done_seen = 0;
		start = 1'b1;
		cfg = '{w_in: row.w_in, ch_groups: row.ch_groups};
		beat = 0;
		k = 0;
		pops = 0;
		cur = next_rand();
		while (beat < total) begin
			@(posedge clk);
			#2;
			start = 1'b0;
			if (row.restart && k == 3) begin
				start = 1'b1;
				cfg = '{w_in: W_BITS'(1), ch_groups: GRP_BITS'(1)};
			end
			vld = row.vld_mask[k % 16];
			grant = row.grant_mask[k % 16];
			rd_resp_vld = vld;
			buf_grant = grant;
			rd_dat = cur;
			@(negedge clk);
			check_bit("busy", 1'b1, busy);
			check_bit("done", 1'b0, done);
			check_bit("rd_resp_rdy", grant, rd_resp_rdy);
			check_bit("rd_fifo_pop", vld & grant, rd_fifo_pop);
			if (rd_fifo_pop === 1'b1) begin
				pops++;
			end
			if (vld && grant) begin
				model[exp_addr[beat]] = cur;
				beat++;
				cur = next_rand();
			end
			k++;
		end
		@(posedge clk);
		#2;
		start = 1'b0;
		rd_resp_vld = 1'b0;
		buf_grant = 1'b1;
		// done lands exactly one cycle after the final transfer
		@(negedge clk);
		check_bit("done", 1'b1, done);
		check_bit("busy", 1'b0, busy);
		check_count("rd_fifo_pop count", int'(row.w_in) * int'(row.ch_groups), pops);
		foreach (exp_addr[i]) begin
			@(posedge clk);
			#2;
			rd_en = 1'b1;
			rd_addr = BUF_AW'(exp_addr[i]);
			@(posedge clk);
			#2;
			rd_en = 1'b0;
			@(negedge clk);
			check_beat($sformatf("rd_q[%0d]", exp_addr[i]), model[exp_addr[i]], rd_q);
		end
		check_count("done pulses", 1, done_seen);
		report_test($sformatf("test %0d w_in=%0d groups=%0d beats=%0d", idx, row.w_in,
			row.ch_groups, total), err0);
	endtask

	// watchdog sized from the table
	initial begin
		int unsigned limit;
		@(posedge rst_n);
		limit = 0;
		foreach (tests[i]) begin
			limit += int'(tests[i].w_in) * int'(tests[i].ch_groups) * 4 + 40;
		end
		repeat (limit) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		cfg = '0;
		rd_resp_vld = 1'b0;
		rd_dat = '0;
		buf_grant = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;

		// full tiles, partial last bursts, then stalls
		add_row(16, 4, 16'hffff, 16'hffff, 1'b0);
		add_row(32, 4, 16'hffff, 16'hffff, 1'b0);
		add_row(5, 3, 16'hffff, 16'hffff, 1'b0);
		add_row(13, 2, 16'hffff, 16'hffff, 1'b0);
		add_row(1, 1, 16'hffff, 16'hffff, 1'b0);
		add_row(13, 3, 16'hb6db, 16'hdddd, 1'b0);
		add_row(16, 2, 16'hffff, 16'h0ff3, 1'b1);

		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;

		check_idle();
		foreach (tests[i]) begin
			run_tile(i + 1, tests[i]);
		end

		repeat (2) @(posedge clk);
		$display("tests=%0d checks=%0d errors=%0d", tests.size() + 1, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- sim.f
transpose_cfg_pkg.sv
transpose_types_pkg.sv
transpose_ctrl.sv
transpose_counters.sv
transpose_addr_gen.sv
transpose_buffer.sv
transpose_unit.sv
tb_transpose_unit.sv

//--- Bender.yml
package:
  name: transpose_unit

sources:
  - files:
      - transpose_cfg_pkg.sv
      - transpose_types_pkg.sv
      - transpose_ctrl.sv
      - transpose_counters.sv
      - transpose_addr_gen.sv
      - transpose_buffer.sv
      - transpose_unit.sv
  - target: test
    files:
      - tb_transpose_unit.sv
